/* rtl/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    localparam int ADDR_W         = 32;
    localparam int LINE_BYTES     = 32;
    localparam int OFFSET_W       = 5;
    localparam int LINE_W         = LINE_BYTES * 8;
    localparam int WORDS_PER_LINE = 8;
    localparam int UNCACHED_BIT   = 31;

    localparam logic [ADDR_W-1:0] RESET_PC_DEFAULT = 32'h0000_1000;

    // field view assumes the default 128 sets
    localparam int FA_INDEX_W = 7;
    localparam int FA_TAG_W   = ADDR_W - OFFSET_W - FA_INDEX_W;

    typedef struct packed {
        logic [FA_TAG_W-1:0]   tag;
        logic [FA_INDEX_W-1:0] index;
        logic [2:0]            word;     // word within line
        logic [1:0]            byte_off;
    } fetch_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        fetch_fields_t     f;
    } fetch_addr_u;

endpackage

`default_nettype wire

/* rtl/icache_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 128
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     en_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic [WIDTH-1:0]         wdata_i,
    output logic [WIDTH-1:0]         rdata_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en_i && we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // read-first, holds while en_i is low
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_o <= '0;
        end else if (en_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

/* rtl/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int SETS = 128
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          redirect_i,
    input  logic                          lookup_valid_i,
    input  logic [icache_pkg::ADDR_W-1:0] lookup_pc_i,
    output logic                          lookup_ready_o,
    input  logic                          inv_req_i,
    input  logic [icache_pkg::ADDR_W-1:0] inv_addr_i,
    output logic                          inv_ack_o,
    output logic                          refill_req_o,
    output logic [icache_pkg::ADDR_W-1:0] refill_addr_o,
    input  logic                          refill_ack_i,
    input  logic [icache_pkg::LINE_W-1:0] refill_data_i,
    output logic                          unc_req_o,
    output logic [icache_pkg::ADDR_W-1:0] unc_addr_o,
    input  logic                          unc_ack_i,
    input  logic [31:0]                   unc_data_i,
    output logic                          inst_valid_o,
    output logic [31:0]                   inst_o,
    output logic [icache_pkg::ADDR_W-1:0] inst_pc_o,
    input  logic                          out_ready_i
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

    localparam logic [2:0] S_INIT   = 3'd0;
    localparam logic [2:0] S_RUN    = 3'd1;
    localparam logic [2:0] S_REFILL = 3'd2;
    localparam logic [2:0] S_UNC    = 3'd3;
    localparam logic [2:0] S_WAIT   = 3'd4;
    localparam logic [2:0] S_INV    = 3'd5;

    logic [2:0]        state;
    logic [IDX_W-1:0]  init_cnt;
    logic              s1_valid;
    logic [ADDR_W-1:0] s1_pc;
    logic              s2_valid;
    fetch_addr_u       s2_addr;
    logic [IDX_W-1:0]  s1_idx;
    logic [IDX_W-1:0]  s2_idx;
    logic [IDX_W-1:0]  inv_idx;
    logic [IDX_W-1:0]  wr_idx;
    logic [IDX_W-1:0]  ram_addr;
    logic [TAG_W-1:0]  s2_tag;
    logic [TAG_W:0]    tag_q [2];     // {valid, tag}
    logic [LINE_W-1:0] data_q [2];
    logic [TAG_W:0]    tag_wdata;
    logic [1:0]        hit;
    logic [1:0]        tag_we;
    logic [1:0]        data_we;
    logic [SETS-1:0]   lru;           // way to replace next
    logic              victim;
    logic              s2_unc;
    logic              s2_hit;
    logic              s2_miss;
    logic              out_free;
    logic              s2_out;
    logic              deliver;
    logic              advance;
    logic              fire;
    logic              inv_start;
    logic              refill_wr;
    logic              tag_clear;
    logic [31:0]       hit_word;
    logic [31:0]       miss_word;

    assign s1_idx  = s1_pc[OFFSET_W +: IDX_W];
    assign s2_idx  = s2_addr.raw[OFFSET_W +: IDX_W];
    assign s2_tag  = s2_addr.raw[ADDR_W-1 -: TAG_W];
    assign inv_idx = inv_addr_i[OFFSET_W +: IDX_W];
    assign s2_unc  = s2_addr.raw[UNCACHED_BIT];

    // stage 2 compare
    assign s2_hit   = !s2_unc && (hit != 2'b00);
    assign s2_miss  = s2_valid && !s2_hit;
    assign hit_word = hit[0] ? data_q[0][s2_addr.f.word * 32 +: 32]
                             : data_q[1][s2_addr.f.word * 32 +: 32];
    assign victim   = lru[s2_idx];

    assign out_free = !inst_valid_o || out_ready_i;
    assign s2_out   = (state == S_RUN) && s2_valid && s2_hit && out_free;
    assign deliver  = (state == S_WAIT) && !refill_ack_i && !unc_ack_i && s2_valid && out_free;
    assign advance  = (state == S_RUN) && !inv_req_i && s1_valid && (!s2_valid || s2_out);

    assign lookup_ready_o = (state == S_RUN) && !inv_req_i && !s2_miss
                            && (!s1_valid || advance);
    assign fire = lookup_valid_i && lookup_ready_o;

    assign inv_start = (state == S_RUN) && inv_req_i && !s2_valid;
    assign refill_wr = (state == S_REFILL) && refill_ack_i;
    assign tag_clear = (state == S_INIT) || inv_start;

    assign wr_idx    = (state == S_INIT) ? init_cnt : (inv_start ? inv_idx : s2_idx);
    assign ram_addr  = (tag_clear || refill_wr) ? wr_idx : s1_idx;
    assign tag_wdata = refill_wr ? {1'b1, s2_tag} : '0;

    assign refill_addr_o = {s2_addr.raw[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign unc_addr_o    = s2_addr.raw;

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign tag_we[w]  = tag_clear || (refill_wr && (victim == 1'(w)));
        assign data_we[w] = refill_wr && (victim == 1'(w));
        assign hit[w]     = tag_q[w][TAG_W] && (tag_q[w][TAG_W-1:0] == s2_tag);

        icache_ram #(
            .WIDTH(TAG_W + 1),
            .DEPTH(SETS)
        ) i_tag_ram (
            .clk(clk),
            .reset(reset),
            .en_i(advance || tag_we[w]),
            .we_i(tag_we[w]),
            .addr_i(ram_addr),
            .wdata_i(tag_wdata),
            .rdata_o(tag_q[w])
        );

        icache_ram #(
            .WIDTH(LINE_W),
            .DEPTH(SETS)
        ) i_data_ram (
            .clk(clk),
            .reset(reset),
            .en_i(advance || data_we[w]),
            .we_i(data_we[w]),
            .addr_i(ram_addr),
            .wdata_i(refill_data_i),
            .rdata_o(data_q[w])
        );
    end

    always_ff @(posedge clk) begin
        if (reset || redirect_i) begin
            s1_valid <= 1'b0;
        end else if (fire) begin
            s1_valid <= 1'b1;
        end else if (advance) begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            s1_pc <= lookup_pc_i;
        end
        if (advance) begin
            s2_addr.raw <= s1_pc;     // RAM read happens on the same edge
        end
    end

    always_ff @(posedge clk) begin
        if (reset || redirect_i) begin
            s2_valid <= 1'b0;
        end else if (advance) begin
            s2_valid <= 1'b1;
        end else if (s2_out || deliver) begin
            s2_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (refill_wr) begin
            lru[s2_idx] <= !victim;
        end else if (s2_out) begin
            lru[s2_idx] <= hit[0];
        end
    end

    always_ff @(posedge clk) begin
        if (refill_wr) begin
            miss_word <= refill_data_i[s2_addr.f.word * 32 +: 32];
        end else if (state == S_UNC && unc_ack_i) begin
            miss_word <= unc_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= S_INIT;
            init_cnt     <= '0;
            refill_req_o <= 1'b0;
            unc_req_o    <= 1'b0;
            inv_ack_o    <= 1'b0;
        end else begin
            case (state)
                S_INIT: begin  // clear all tags after reset
                    init_cnt <= init_cnt + 1'b1;
                    if (init_cnt == IDX_W'(SETS - 1)) begin
                        state <= S_RUN;
                    end
                end
                S_RUN: begin
                    if (s2_miss && !redirect_i) begin
                        if (s2_unc) begin
                            unc_req_o <= 1'b1;
                            state     <= S_UNC;
                        end else begin
                            refill_req_o <= 1'b1;
                            state        <= S_REFILL;
                        end
                    end else if (inv_start) begin
                        inv_ack_o <= 1'b1;
                        state     <= S_INV;
                    end
                end
                S_REFILL: begin
                    if (refill_ack_i) begin
                        refill_req_o <= 1'b0;
                        state        <= S_WAIT;
                    end
                end
                S_UNC: begin
                    if (unc_ack_i) begin
                        unc_req_o <= 1'b0;
                        state     <= S_WAIT;
                    end
                end
                S_WAIT: begin  // ack low, then hand over the word unless killed
                    if (!refill_ack_i && !unc_ack_i
                        && (!s2_valid || out_free || redirect_i)) begin
                        state <= S_RUN;
                    end
                end
                S_INV: begin
                    if (!inv_req_i) begin
                        inv_ack_o <= 1'b0;
                        state     <= S_RUN;
                    end
                end
                default: state <= S_RUN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || redirect_i) begin
            inst_valid_o <= 1'b0;
        end else if (out_free) begin
            inst_valid_o <= s2_out || deliver;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_out || deliver) begin
            inst_o    <= deliver ? miss_word : hit_word;
            inst_pc_o <= s2_addr.raw;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [icache_pkg::ADDR_W-1:0] RESET_PC = icache_pkg::RESET_PC_DEFAULT
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          redirect_i,
    input  logic [icache_pkg::ADDR_W-1:0] redirect_pc_i,
    output logic                          lookup_valid_o,
    output logic [icache_pkg::ADDR_W-1:0] lookup_pc_o,
    input  logic                          lookup_ready_i
);
    import icache_pkg::*;

    // one instruction word
    localparam logic [ADDR_W-1:0] PC_STEP = ADDR_W'(LINE_BYTES / WORDS_PER_LINE);

    logic [ADDR_W-1:0] pc;

    assign lookup_pc_o = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc             <= RESET_PC;
            lookup_valid_o <= 1'b0;
        end else begin
            lookup_valid_o <= 1'b1;  // offer every cycle once out of reset
            if (redirect_i) begin
                pc <= redirect_pc_i;
            end else if (lookup_valid_o && lookup_ready_i) begin
                pc <= pc + PC_STEP;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int                            SETS     = 128,
    parameter logic [icache_pkg::ADDR_W-1:0] RESET_PC = icache_pkg::RESET_PC_DEFAULT
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          redirect_i,
    input  logic [icache_pkg::ADDR_W-1:0] redirect_pc_i,
    input  logic                          inv_req_i,
    input  logic [icache_pkg::ADDR_W-1:0] inv_addr_i,
    output logic                          inv_ack_o,
    output logic                          refill_req_o,
    output logic [icache_pkg::ADDR_W-1:0] refill_addr_o,
    input  logic                          refill_ack_i,
    input  logic [icache_pkg::LINE_W-1:0] refill_data_i,
    output logic                          unc_req_o,
    output logic [icache_pkg::ADDR_W-1:0] unc_addr_o,
    input  logic                          unc_ack_i,
    input  logic [31:0]                   unc_data_i,
    output logic                          inst_valid_o,
    output logic [31:0]                   inst_o,
    output logic [icache_pkg::ADDR_W-1:0] inst_pc_o,
    input  logic                          out_ready_i
);
    import icache_pkg::*;

    logic              lookup_valid;
    logic [ADDR_W-1:0] lookup_pc;
    logic              lookup_ready;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) i_fetch_unit (
        .clk(clk),
        .reset(reset),
        .redirect_i(redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .lookup_valid_o(lookup_valid),
        .lookup_pc_o(lookup_pc),
        .lookup_ready_i(lookup_ready)
    );

    icache #(
        .SETS(SETS)
    ) i_icache (
        .clk(clk),
        .reset(reset),
        .redirect_i(redirect_i),       // kills lookups in flight
        .lookup_valid_i(lookup_valid),
        .lookup_pc_i(lookup_pc),
        .lookup_ready_o(lookup_ready),
        .inv_req_i(inv_req_i),
        .inv_addr_i(inv_addr_i),
        .inv_ack_o(inv_ack_o),
        .refill_req_o(refill_req_o),
        .refill_addr_o(refill_addr_o),
        .refill_ack_i(refill_ack_i),
        .refill_data_i(refill_data_i),
        .unc_req_o(unc_req_o),
        .unc_addr_o(unc_addr_o),
        .unc_ack_i(unc_ack_i),
        .unc_data_i(unc_data_i),
        .inst_valid_o(inst_valid_o),
        .inst_o(inst_o),
        .inst_pc_o(inst_pc_o),
        .out_ready_i(out_ready_i)
    );

endmodule

`default_nettype wire

/* tests/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
    parameter logic [31:0] CACHED_KEY = 32'h5a5a_0000,
    parameter int          MAX_DELAY  = 6,
    parameter logic [31:0] SEED       = 32'h8de3_4ff7
) (
    input  logic                          clk,
    input  logic                          refill_req_i,
    input  logic [31:0]                   refill_addr_i,
    output logic                          refill_ack_o,
    output logic [icache_pkg::LINE_W-1:0] refill_data_o,
    input  logic                          unc_req_i,
    input  logic [31:0]                   unc_addr_i,
    output logic                          unc_ack_o,
    output logic [31:0]                   unc_data_o,
    output int                            refill_cnt_o,
    output int                            unc_cnt_o
);
    import icache_pkg::*;

    integer seed = SEED;

    // 1 to MAX_DELAY cycles
    function automatic int pick_delay();
        return 1 + int'({$random(seed)} % MAX_DELAY);
    endfunction

    initial begin
        logic [31:0] line;
        refill_ack_o  = 1'b0;
        refill_data_o = '0;
        refill_cnt_o  = 0;
        forever begin
            @(posedge clk);
            #1;
            if (refill_req_i === 1'b1) begin
                refill_cnt_o++;
                line = {refill_addr_i[31:OFFSET_W], {OFFSET_W{1'b0}}};
                repeat (pick_delay()) @(posedge clk);
                #1;
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    refill_data_o[w*32 +: 32] = (line + 32'(w * 4)) ^ CACHED_KEY;
                end
                refill_ack_o = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (refill_req_i);
                refill_ack_o = 1'b0;  // req is low, close the handshake
            end
        end
    end

    initial begin
        unc_ack_o  = 1'b0;
        unc_data_o = '0;
        unc_cnt_o  = 0;
        forever begin
            @(posedge clk);
            #1;
            if (unc_req_i === 1'b1) begin
                unc_cnt_o++;
                repeat (pick_delay()) @(posedge clk);
                #1;
                unc_data_o = ~unc_addr_i;
                unc_ack_o  = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (unc_req_i);
                unc_ack_o = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;
    import icache_pkg::*;

    localparam logic [31:0] RESET_PC   = RESET_PC_DEFAULT;
    localparam logic [31:0] CACHED_KEY = 32'h5a5a_0000;
    localparam logic [31:0] SEED       = 32'h8de3_4ff7;
    localparam int          MAX_DELAY  = 6;
    localparam int          TEST_WORDS = 40;  // accepted words over all tests, rounded up
    localparam int          WATCHDOG_CYCLES = 8 + 128 + TEST_WORDS * (4 * MAX_DELAY + 8);
    localparam int          WAIT_LIMIT = 200;

    logic              clk;
    logic              reset;
    logic              redirect;
    logic [31:0]       redirect_pc;
    logic              inv_req;
    logic [31:0]       inv_addr;
    logic              inv_ack;
    logic              refill_req;
    logic [31:0]       refill_addr;
    logic              refill_ack;
    logic [LINE_W-1:0] refill_data;
    logic              unc_req;
    logic [31:0]       unc_addr;
    logic              unc_ack;
    logic [31:0]       unc_data;
    logic              inst_valid;
    logic [31:0]       inst;
    logic [31:0]       inst_pc;
    logic              out_ready;
    logic              random_ready;
    logic              want_target;
    logic [31:0]       target_pc;
    logic [31:0]       last_pc;
    logic [31:0]       next_pc_exp;
    logic              refill_prev;
    int                refill_cnt;
    int                unc_cnt;
    int                errors;
    int                tests_done;
    integer            seed;
    int                line_refills [logic [31:0]];
    fetch_addr_u       addr_a;
    fetch_addr_u       addr_b;
    fetch_addr_u       addr_c;

    always #5 clk = ~clk;

    fetch_top #(
        .SETS(128),
        .RESET_PC(RESET_PC)
    ) i_fetch_top (
        .clk(clk), .reset(reset),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .inv_req_i(inv_req), .inv_addr_i(inv_addr), .inv_ack_o(inv_ack),
        .refill_req_o(refill_req), .refill_addr_o(refill_addr),
        .refill_ack_i(refill_ack), .refill_data_i(refill_data),
        .unc_req_o(unc_req), .unc_addr_o(unc_addr), .unc_ack_i(unc_ack), .unc_data_i(unc_data),
        .inst_valid_o(inst_valid), .inst_o(inst), .inst_pc_o(inst_pc), .out_ready_i(out_ready)
    );

    mem_model #(
        .CACHED_KEY(CACHED_KEY), .MAX_DELAY(MAX_DELAY), .SEED(SEED)
    ) i_mem_model (
        .clk(clk),
        .refill_req_i(refill_req), .refill_addr_i(refill_addr),
        .refill_ack_o(refill_ack), .refill_data_o(refill_data),
        .unc_req_i(unc_req), .unc_addr_i(unc_addr), .unc_ack_o(unc_ack), .unc_data_o(unc_data),
        .refill_cnt_o(refill_cnt), .unc_cnt_o(unc_cnt)
    );

    function automatic logic [31:0] expected_word(input logic [31:0] pc);
        return pc[UNCACHED_BIT] ? ~pc : pc ^ CACHED_KEY;
    endfunction

    function automatic int refills_of(input logic [31:0] line);
        if (line_refills.exists(line)) begin
            return line_refills[line];
        end
        return 0;
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic report_test(input int num, input string name);
        tests_done++;
        $display("test %0d %s done, errors so far %0d", num, name, errors);
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        redirect    = 1'b1;
        redirect_pc = pc;
        @(posedge clk);
        #1;
        redirect = 1'b0;
    endtask

    task automatic wait_accept(output logic [31:0] pc);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(inst_valid && out_ready)) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("timeout waiting for an instruction");
            end
            @(negedge clk);
        end
        pc = inst_pc;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_refill(input logic [31:0] line);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(refill_req && refill_addr == line)) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("timeout waiting for a refill request");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_inv_ack(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (inv_ack !== level) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("timeout waiting for the invalidate ack");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        #1;
        if (random_ready) begin
            out_ready = ($random(seed) & 3) != 0;  // ready about 3 cycles in 4
        end else begin
            out_ready = 1'b1;
        end
    end

    // next PC the output stream should show
    always @(posedge clk) begin
        if (reset || redirect) begin
            want_target <= 1'b1;
            target_pc   <= reset ? RESET_PC : redirect_pc;
        end else if (inst_valid && out_ready) begin
            want_target <= 1'b0;
            last_pc     <= inst_pc;
        end
    end
    assign next_pc_exp = want_target ? target_pc : last_pc + 32'd4;

    always @(negedge clk) begin
        if (refill_req && !refill_prev) begin
            line_refills[refill_addr] = refills_of(refill_addr) + 1;
        end
        refill_prev = refill_req;
    end

    a_word: assert property (@(posedge clk) disable iff (reset)
        inst_valid && out_ready |-> inst == expected_word(inst_pc))
        else log_error($sformatf("ERR inst_o: pc %h got %h expected %h", $sampled(inst_pc),
                                 $sampled(inst), expected_word($sampled(inst_pc))));
    a_order: assert property (@(posedge clk) disable iff (reset)
        inst_valid && out_ready |-> inst_pc == next_pc_exp)
        else log_error($sformatf("ERR inst_pc_o: got %h expected %h",
                                 $sampled(inst_pc), $sampled(next_pc_exp)));
    a_hold: assert property (@(posedge clk) disable iff (reset)
        inst_valid && !out_ready && !redirect |=> inst_valid && $stable(inst) && $stable(inst_pc))
        else log_error("held output changed while out_ready_i was low");
    a_refill_hold: assert property (@(posedge clk) disable iff (reset)
        refill_req && !refill_ack |=> refill_req && $stable(refill_addr))
        else log_error("refill_req_o dropped or its address moved before the ack");
    a_refill_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(refill_req) |-> !refill_ack)
        else log_error("refill_req_o rose while refill_ack_i was still high");
    a_refill_cached: assert property (@(posedge clk) disable iff (reset)
        refill_req |-> !refill_addr[UNCACHED_BIT])
        else log_error("refill requested for an uncached address");
    a_unc_hold: assert property (@(posedge clk) disable iff (reset)
        unc_req && !unc_ack |=> unc_req && $stable(unc_addr))
        else log_error("unc_req_o dropped or its address moved before the ack");
    a_unc_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(unc_req) |-> !unc_ack)
        else log_error("unc_req_o rose while unc_ack_i was still high");
    a_inv_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(inv_ack) |-> inv_req)
        else log_error("inv_ack_o rose without a request");
    a_inv_hold: assert property (@(posedge clk) disable iff (reset)
        inv_ack && inv_req |=> inv_ack)
        else log_error("inv_ack_o dropped while inv_req_i was still high");

    initial begin
        logic [31:0] pc;
        int          n;
        int          unc_start;
        int          refill_start;
        clk          = 1'b0;
        reset        = 1'b1;
        redirect     = 1'b0;
        redirect_pc  = '0;
        inv_req      = 1'b0;
        inv_addr     = '0;
        out_ready    = 1'b1;
        random_ready = 1'b0;
        refill_prev  = 1'b0;
        errors       = 0;
        tests_done   = 0;
        seed         = SEED;
        addr_a.raw     = '0;
        addr_a.f.index = 7'h15;  // A, B and C share set 0x15
        addr_a.f.tag   = 20'h00100;
        addr_b         = addr_a;
        addr_b.f.tag   = 20'h00200;
        addr_c         = addr_a;
        addr_c.f.tag   = 20'h00300;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        assert (!inst_valid && !refill_req && !unc_req && !inv_ack
                && !i_fetch_top.lookup_valid)
            else log_error("control outputs not low after reset");
        wait_accept(pc);
        assert (refill_cnt == 1 && refills_of(RESET_PC) == 1)
            else log_error($sformatf("ERR refill_req_o: count %h expected %h", refill_cnt, 1));
        report_test(1, "reset and cold miss");

        random_ready = 1'b1;
        for (int i = 0; i < WORDS_PER_LINE - 1; i++) begin
            wait_accept(pc);
        end
        random_ready = 1'b0;
        assert (refills_of(RESET_PC) == 1)
            else log_error("line at the reset PC was refilled again");
        report_test(2, "streaming hits with back-pressure");

        redirect_to(addr_a.raw);
        wait_accept(pc);
        redirect_to(addr_b.raw);
        wait_accept(pc);
        redirect_to(addr_a.raw);
        wait_accept(pc);
        redirect_to(addr_c.raw);  // evicts B, the older way
        wait_accept(pc);
        redirect_to(addr_a.raw);
        wait_accept(pc);
        redirect_to(addr_b.raw);
        wait_accept(pc);
        assert (refills_of(addr_a.raw) == 1)
            else log_error($sformatf("ERR refill_req_o: line A count %h expected %h",
                                     refills_of(addr_a.raw), 1));
        assert (refills_of(addr_b.raw) == 2)
            else log_error($sformatf("ERR refill_req_o: line B count %h expected %h",
                                     refills_of(addr_b.raw), 2));
        report_test(3, "LRU replacement");

        redirect_to(32'h0000_4000);
        wait_refill(32'h0000_4000);
        redirect_to(32'h0000_6040);
        wait_accept(pc);
        assert (pc == 32'h0000_6040)
            else log_error($sformatf("ERR inst_pc_o: got %h expected %h", pc, 32'h0000_6040));
        for (int i = 0; i < 3; i++) begin
            wait_accept(pc);
        end
        report_test(4, "redirect during refill");

        n        = refills_of(addr_a.raw);
        inv_addr = addr_a.raw;
        inv_req  = 1'b1;
        wait_inv_ack(1'b1);
        inv_req = 1'b0;
        wait_inv_ack(1'b0);
        redirect_to(addr_a.raw);
        wait_accept(pc);
        assert (refills_of(addr_a.raw) == n + 1)
            else log_error($sformatf("ERR refill_req_o: line A count %h expected %h",
                                     refills_of(addr_a.raw), n + 1));
        report_test(5, "invalidate");

        unc_start = unc_cnt;
        for (int r = 0; r < 2; r++) begin
            redirect_to(32'h8000_0000);
            refill_start = refill_cnt;  // a refill of the old path may still finish
            for (int i = 0; i < 4; i++) begin
                wait_accept(pc);
            end
            assert (refill_cnt == refill_start)
                else log_error($sformatf("ERR refill_req_o: count %h expected %h",
                                         refill_cnt, refill_start));
        end
        assert (unc_cnt - unc_start >= 8)
            else log_error($sformatf("ERR unc_req_o: count %h expected at least %h",
                                     unc_cnt - unc_start, 8));
        report_test(6, "uncached region");

        $display("tests run %0d, errors %0d", tests_done, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

/* fetch_top.f */
rtl/icache_pkg.sv
rtl/icache_ram.sv
rtl/icache.sv
rtl/fetch_unit.sv
rtl/fetch_top.sv
tests/mem_model.sv
tests/tb_fetch_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f fetch_top.f --top-module tb_fetch_top -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
exit 0
